/* verilog/rv_isa_pkg.sv */
// rv32i subset ISA: instruction word views, opcodes and funct3 codes
`default_nettype none

package rv_isa_pkg;

	localparam int xlen = 32;

	typedef logic [4:0] reg_addr_t;

	// ------------------------------------------------------------
	// instruction formats, msb first
	// ------------------------------------------------------------
	typedef struct packed {
		logic [6:0] funct7;
		reg_addr_t  rs2;
		reg_addr_t  rs1;
		logic [2:0] funct3;
		reg_addr_t  rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm11_0;
		reg_addr_t   rs1;
		logic [2:0]  funct3;
		reg_addr_t   rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm11_5;
		reg_addr_t  rs2;
		reg_addr_t  rs1;
		logic [2:0] funct3;
		logic [4:0] imm4_0;
		logic [6:0] opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		reg_addr_t  rs2;
		reg_addr_t  rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	// one word, read through whichever format the opcode selects
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		b_fmt_t b_fmt;
	} instr_t;

	localparam logic [6:0] op_r      = 7'b0110011;
	localparam logic [6:0] op_imm    = 7'b0010011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_branch = 7'b1100011;

	localparam logic [2:0] f3_add = 3'b000;
	localparam logic [2:0] f3_slt = 3'b010;
	localparam logic [2:0] f3_or  = 3'b110;
	localparam logic [2:0] f3_and = 3'b111;
	localparam logic [2:0] f3_beq = 3'b000;
	localparam logic [2:0] f3_bne = 3'b001;

	// addi x0, x0, 0
	localparam logic [xlen-1:0] nop_word = 32'h0000_0013;

endpackage

`default_nettype wire

/* verilog/rv_pipe_pkg.sv */
// pipeline records: stage registers, ALU ops, forwarding and data port
`default_nettype none

package rv_pipe_pkg;

	import rv_isa_pkg::*;

	typedef enum logic [2:0] {
		alu_add = 3'd0,
		alu_sub = 3'd1,
		alu_and = 3'd2,
		alu_or  = 3'd3,
		alu_slt = 3'd4
	} alu_op_t;

	typedef struct packed {
		logic    regwrite;
		logic    memread;
		logic    memwrite;
		logic    branch;
		logic    branch_ne;
		logic    alusrc;
		alu_op_t alu_op;
	} ctrl_t;

	// ------------------------------------------------------------
	// stage registers
	// ------------------------------------------------------------
	typedef struct packed {
		logic [xlen-1:0] pc;
		instr_t          instr;
	} if_id_t;

	typedef struct packed {
		ctrl_t           ctrl;
		logic [xlen-1:0] pc;
		logic [xlen-1:0] rs1_data;
		logic [xlen-1:0] rs2_data;
		logic [xlen-1:0] imm;
		reg_addr_t       rs1;
		reg_addr_t       rs2;
		reg_addr_t       rd;
	} id_ex_t;

	typedef struct packed {
		logic            regwrite;
		logic            memread;
		logic            memwrite;
		logic [xlen-1:0] alu_result;
		logic [xlen-1:0] store_data;
		reg_addr_t       rd;
	} ex_mem_t;

	typedef struct packed {
		logic            regwrite;
		logic            memread;
		logic [xlen-1:0] alu_result;
		logic [xlen-1:0] load_data;
		reg_addr_t       rd;
	} mem_wb_t;

	typedef enum logic [1:0] {
		fwd_none = 2'b00,
		fwd_wb   = 2'b01,
		fwd_mem  = 2'b10
	} fwd_sel_t;

	// word addressed
	typedef struct packed {
		logic            ren;
		logic            wen;
		logic [xlen-3:0] addr;
		logic [xlen-1:0] wdata;
	} dmem_req_t;

	typedef struct packed {
		logic            regwrite;
		reg_addr_t       rd;
		logic [xlen-1:0] data;
	} wb_t;

endpackage

`default_nettype wire

/* verilog/rv_fetch.sv */
// fetch stage: program counter and if/id register with hold and flush
`timescale 1ns/1ns
`default_nettype none

module rv_fetch import rv_isa_pkg::*, rv_pipe_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            stall,
	input  logic            load_use,
	input  logic            branch_taken,
	input  logic [xlen-1:0] branch_target,
	output logic [xlen-3:0] imem_addr,
	input  instr_t          imem_data,
	output if_id_t          if_id
);

	logic [xlen-1:0] pc;

	assign imem_addr = pc[xlen-1:2];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc          <= '0;
			if_id.pc    <= '0;
			if_id.instr <= nop_word;
		end else if (!stall) begin
			if (branch_taken) begin
				// redirect, drop the instruction fetched behind the branch
				pc          <= branch_target;
				if_id.pc    <= '0;
				if_id.instr <= nop_word;
			end else if (!load_use) begin
				pc          <= pc + 32'd4;
				if_id.pc    <= pc;
				if_id.instr <= imem_data;
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/rv_regfile.sv */
// register file: 32 x 32, x0 hardwired, write-through on read
`timescale 1ns/1ns
`default_nettype none

module rv_regfile import rv_isa_pkg::*, rv_pipe_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	input  reg_addr_t       rs1,
	input  reg_addr_t       rs2,
	output logic [xlen-1:0] rs1_data,
	output logic [xlen-1:0] rs2_data,
	input  wb_t             wb
);

	logic [xlen-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.regwrite && wb.rd != '0) begin
			regs[wb.rd] <= wb.data;
		end
	end

	// same-cycle writeback bypasses the array
	assign rs1_data = (rs1 == '0) ? '0 :
		(wb.regwrite && wb.rd == rs1) ? wb.data : regs[rs1];
	assign rs2_data = (rs2 == '0) ? '0 :
		(wb.regwrite && wb.rd == rs2) ? wb.data : regs[rs2];

endmodule

`default_nettype wire

/* verilog/rv_decode.sv */
// decode stage: control decode, immediate build and id/ex register
`timescale 1ns/1ns
`default_nettype none

module rv_decode import rv_isa_pkg::*, rv_pipe_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   stall,
	input  logic   load_use,
	input  logic   branch_taken,
	input  if_id_t if_id,
	input  wb_t    wb,
	output id_ex_t id_ex
);

	instr_t          instr;
	ctrl_t           ctrl;
	logic [xlen-1:0] imm;
	logic [xlen-1:0] rs1_data;
	logic [xlen-1:0] rs2_data;

	assign instr = if_id.instr;

	rv_regfile u_regfile (
		.clk      (clk),
		.rst_n    (rst_n),
		.rs1      (instr.r_fmt.rs1),
		.rs2      (instr.r_fmt.rs2),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.wb       (wb)
	);

	// shared by R and I ALU ops, sub only exists for R
	function automatic alu_op_t alu_decode(input logic [2:0] f3, input logic sub);
		case (f3)
			f3_add:  return sub ? alu_sub : alu_add;
			f3_slt:  return alu_slt;
			f3_or:   return alu_or;
			f3_and:  return alu_and;
			default: return alu_add;
		endcase
	endfunction

	// ------------------------------------------------------------
	// control
	// ------------------------------------------------------------
	always_comb begin
		ctrl = '0;
		case (instr.r_fmt.opcode)
			op_r: begin
				ctrl.regwrite = 1'b1;
				ctrl.alu_op   = alu_decode(instr.r_fmt.funct3, instr.r_fmt.funct7[5]);
			end
			op_imm: begin
				ctrl.regwrite = 1'b1;
				ctrl.alusrc   = 1'b1;
				ctrl.alu_op   = alu_decode(instr.i_fmt.funct3, 1'b0);
			end
			op_load: begin
				ctrl.regwrite = 1'b1;
				ctrl.memread  = 1'b1;
				ctrl.alusrc   = 1'b1;
			end
			op_store: begin
				ctrl.memwrite = 1'b1;
				ctrl.alusrc   = 1'b1;
			end
			op_branch: begin
				ctrl.branch    = (instr.b_fmt.funct3 == f3_beq) || (instr.b_fmt.funct3 == f3_bne);
				ctrl.branch_ne = (instr.b_fmt.funct3 == f3_bne);
			end
			default: ctrl = '0;
		endcase
	end

	// sign-extended immediate per format
	always_comb begin
		case (instr.r_fmt.opcode)
			op_store: imm = {{20{instr.s_fmt.imm11_5[6]}}, instr.s_fmt.imm11_5,
				instr.s_fmt.imm4_0};
			op_branch: imm = {{19{instr.b_fmt.imm12}}, instr.b_fmt.imm12, instr.b_fmt.imm11,
				instr.b_fmt.imm10_5, instr.b_fmt.imm4_1, 1'b0};
			default: imm = {{20{instr.i_fmt.imm11_0[11]}}, instr.i_fmt.imm11_0};
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			id_ex <= '0;
		end else if (!stall) begin
			if (load_use || branch_taken) begin
				id_ex.ctrl <= '0;
			end else begin
				id_ex.ctrl <= ctrl;
			end
			id_ex.pc       <= if_id.pc;
			id_ex.rs1_data <= rs1_data;
			id_ex.rs2_data <= rs2_data;
			id_ex.imm      <= imm;
			id_ex.rs1      <= instr.r_fmt.rs1;
			id_ex.rs2      <= instr.r_fmt.rs2;
			id_ex.rd       <= instr.r_fmt.rd;
		end
	end

endmodule

`default_nettype wire

/* verilog/rv_hazard.sv */
// hazard unit: load-use detect and forwarding select for execute operands
`timescale 1ns/1ns
`default_nettype none

module rv_hazard import rv_isa_pkg::*, rv_pipe_pkg::*; (
	input  if_id_t   if_id,
	input  id_ex_t   id_ex,
	input  ex_mem_t  ex_mem,
	input  wb_t      wb,
	output logic     load_use,
	output fwd_sel_t fwd_a,
	output fwd_sel_t fwd_b
);

	instr_t instr;
	logic   uses_rs2;

	assign instr = if_id.instr;

	// I-type and loads carry immediate bits in the rs2 field
	assign uses_rs2 = (instr.r_fmt.opcode != op_imm) && (instr.r_fmt.opcode != op_load);

	assign load_use = id_ex.ctrl.memread && (id_ex.rd != '0) &&
		((id_ex.rd == instr.r_fmt.rs1) || (uses_rs2 && id_ex.rd == instr.r_fmt.rs2));

	// newest producer wins
	function automatic fwd_sel_t fwd_pick(input reg_addr_t src, input ex_mem_t mem, input wb_t w);
		if (mem.regwrite && mem.rd != '0 && mem.rd == src) begin
			return fwd_mem;
		end else if (w.regwrite && w.rd != '0 && w.rd == src) begin
			return fwd_wb;
		end
		return fwd_none;
	endfunction

	assign fwd_a = fwd_pick(id_ex.rs1, ex_mem, wb);
	assign fwd_b = fwd_pick(id_ex.rs2, ex_mem, wb);

endmodule

`default_nettype wire

/* verilog/rv_execute.sv */
// execute stage: operand forwarding, ALU, branch resolve and ex/mem register
`timescale 1ns/1ns
`default_nettype none

module rv_execute import rv_isa_pkg::*, rv_pipe_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            stall,
	input  id_ex_t          id_ex,
	input  fwd_sel_t        fwd_a,
	input  fwd_sel_t        fwd_b,
	input  logic [xlen-1:0] mem_result,
	input  wb_t             wb,
	output ex_mem_t         ex_mem,
	output logic            branch_taken,
	output logic [xlen-1:0] branch_target
);

	logic [xlen-1:0] a_val;
	logic [xlen-1:0] b_val;
	logic [xlen-1:0] alu_b;
	logic [xlen-1:0] alu_y;

	function automatic logic [xlen-1:0] operand(input fwd_sel_t sel, input logic [xlen-1:0] rf,
			input logic [xlen-1:0] from_mem, input logic [xlen-1:0] from_wb);
		case (sel)
			fwd_mem: return from_mem;
			fwd_wb:  return from_wb;
			default: return rf;
		endcase
	endfunction

	assign a_val = operand(fwd_a, id_ex.rs1_data, mem_result, wb.data);
	assign b_val = operand(fwd_b, id_ex.rs2_data, mem_result, wb.data);
	// store data keeps the forwarded rs2, not the immediate
	assign alu_b = id_ex.ctrl.alusrc ? id_ex.imm : b_val;

	always_comb begin
		case (id_ex.ctrl.alu_op)
			alu_sub: alu_y = a_val - alu_b;
			alu_and: alu_y = a_val & alu_b;
			alu_or:  alu_y = a_val | alu_b;
			alu_slt: alu_y = {{(xlen-1){1'b0}}, $signed(a_val) < $signed(alu_b)};
			default: alu_y = a_val + alu_b;
		endcase
	end

	assign branch_taken  = id_ex.ctrl.branch && ((a_val == b_val) != id_ex.ctrl.branch_ne);
	assign branch_target = id_ex.pc + id_ex.imm;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_mem <= '0;
		end else if (!stall) begin
			ex_mem.regwrite   <= id_ex.ctrl.regwrite;
			ex_mem.memread    <= id_ex.ctrl.memread;
			ex_mem.memwrite   <= id_ex.ctrl.memwrite;
			ex_mem.alu_result <= alu_y;
			ex_mem.store_data <= b_val;
			ex_mem.rd         <= id_ex.rd;
		end
	end

endmodule

`default_nettype wire

/* verilog/rv_mem_wb.sv */
// memory and writeback: data port drive, mem/wb register, result select
`timescale 1ns/1ns
`default_nettype none

module rv_mem_wb import rv_isa_pkg::*, rv_pipe_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            stall,
	input  ex_mem_t         ex_mem,
	output dmem_req_t       dmem,
	input  logic [xlen-1:0] dmem_rdata,
	output logic [xlen-1:0] mem_result,
	output wb_t             wb
);

	mem_wb_t mem_wb;

	// request stays put while stalled since ex_mem holds
	assign dmem.ren   = ex_mem.memread;
	assign dmem.wen   = ex_mem.memwrite;
	assign dmem.addr  = ex_mem.alu_result[xlen-1:2];
	assign dmem.wdata = ex_mem.store_data;

	assign mem_result = ex_mem.alu_result;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mem_wb <= '0;
		end else if (!stall) begin
			mem_wb.regwrite   <= ex_mem.regwrite;
			mem_wb.memread    <= ex_mem.memread;
			mem_wb.alu_result <= ex_mem.alu_result;
			mem_wb.load_data  <= dmem_rdata;
			mem_wb.rd         <= ex_mem.rd;
		end
	end

	assign wb.regwrite = mem_wb.regwrite;
	assign wb.rd       = mem_wb.rd;
	assign wb.data     = mem_wb.memread ? mem_wb.load_data : mem_wb.alu_result;

endmodule

`default_nettype wire

/* verilog/rv_core.sv */
// five-stage rv32i subset core, stage interconnect
`timescale 1ns/1ns
`default_nettype none

module rv_core import rv_isa_pkg::*, rv_pipe_pkg::*; (
	input  logic            clk,
	input  logic            rst_n,
	output logic [xlen-3:0] imem_addr,
	input  instr_t          imem_data,
	output dmem_req_t       dmem,
	input  logic [xlen-1:0] dmem_rdata,
	input  logic            dmem_stall
);

	if_id_t          if_id;
	id_ex_t          id_ex;
	ex_mem_t         ex_mem;
	wb_t             wb;
	logic            load_use;
	logic            branch_taken;
	logic [xlen-1:0] branch_target;
	logic [xlen-1:0] mem_result;
	fwd_sel_t        fwd_a;
	fwd_sel_t        fwd_b;

	rv_fetch u_fetch (
		.clk(clk), .rst_n(rst_n), .stall(dmem_stall), .load_use(load_use),
		.branch_taken(branch_taken), .branch_target(branch_target),
		.imem_addr(imem_addr), .imem_data(imem_data), .if_id(if_id)
	);

	rv_decode u_decode (
		.clk(clk), .rst_n(rst_n), .stall(dmem_stall), .load_use(load_use),
		.branch_taken(branch_taken), .if_id(if_id), .wb(wb), .id_ex(id_ex)
	);

	rv_hazard u_hazard (
		.if_id(if_id), .id_ex(id_ex), .ex_mem(ex_mem), .wb(wb),
		.load_use(load_use), .fwd_a(fwd_a), .fwd_b(fwd_b)
	);

	rv_execute u_execute (
		.clk(clk), .rst_n(rst_n), .stall(dmem_stall), .id_ex(id_ex),
		.fwd_a(fwd_a), .fwd_b(fwd_b), .mem_result(mem_result), .wb(wb),
		.ex_mem(ex_mem), .branch_taken(branch_taken), .branch_target(branch_target)
	);

	rv_mem_wb u_mem_wb (
		.clk(clk), .rst_n(rst_n), .stall(dmem_stall), .ex_mem(ex_mem),
		.dmem(dmem), .dmem_rdata(dmem_rdata), .mem_result(mem_result), .wb(wb)
	);

endmodule

`default_nettype wire

/* bench/rv_core_tb.sv */
// testbench for the rv32i subset core with program loader, ISA model and store checker
`timescale 1ns/1ns
`default_nettype none

module rv_core_tb import rv_isa_pkg::*, rv_pipe_pkg::*;;

	logic            clk;
	logic            rst_n;
	logic            dmem_stall;
	logic [xlen-3:0] imem_addr;
	instr_t          imem_data;
	dmem_req_t       dmem;
	logic [xlen-1:0] dmem_rdata;

	logic [31:0] prog [64];
	logic [31:0] data_mem [16];
	int          prog_len;
	int          seed = 64;
	logic [31:0] rnd;
	dmem_req_t   exp_q [$];
	logic        all_seen;
	int          cycles;
	int          limit;
	int          n_instr;

	rv_core u_rv_core (
		.clk        (clk),
		.rst_n      (rst_n),
		.imem_addr  (imem_addr),
		.imem_data  (imem_data),
		.dmem       (dmem),
		.dmem_rdata (dmem_rdata),
		.dmem_stall (dmem_stall)
	);

	assign imem_data  = prog[imem_addr[5:0]];
	assign dmem_rdata = data_mem[dmem.addr[3:0]];

	always #50 clk = ~clk;

	// ------------------------------------------------------------
	// instruction encoders
	// ------------------------------------------------------------
	function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, op_r};
	endfunction

	function automatic logic [31:0] i_word(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] s_word(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
	endfunction

	function automatic logic [31:0] b_word(input logic [12:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
	endfunction

	task automatic emit(input logic [31:0] w);
		prog[prog_len] = w;
		prog_len++;
	endtask

	task automatic build_program();
		logic [31:0] r1;
		logic [31:0] r2;
		logic [31:0] r3;
		logic [31:0] r4;
		r1 = $random(seed);
		r2 = $random(seed);
		r3 = $random(seed);
		r4 = $random(seed);
		emit(i_word(r1[11:0], 5'd0, f3_add, 5'd1, op_imm));
		emit(i_word(r2[11:0], 5'd0, f3_add, 5'd2, op_imm));
		emit(i_word(12'd5, 5'd0, f3_add, 5'd12, op_imm));
		// chains one and two apart
		emit(r_word(7'h00, 5'd2, 5'd1, f3_add, 5'd3));
		emit(r_word(7'h20, 5'd1, 5'd3, f3_add, 5'd4));
		emit(r_word(7'h00, 5'd3, 5'd4, f3_and, 5'd5));
		emit(r_word(7'h00, 5'd2, 5'd5, f3_or, 5'd6));
		emit(r_word(7'h00, 5'd2, 5'd1, f3_slt, 5'd7));
		emit(s_word(12'd0, 5'd3, 5'd0));
		emit(s_word(12'd4, 5'd4, 5'd0));
		emit(s_word(12'd8, 5'd5, 5'd0));
		emit(s_word(12'd12, 5'd6, 5'd0));
		emit(s_word(12'd16, 5'd7, 5'd0));
		emit(i_word(r3[11:0], 5'd1, f3_and, 5'd8, op_imm));
		emit(i_word(r4[11:0], 5'd2, f3_or, 5'd9, op_imm));
		emit(s_word(12'd20, 5'd8, 5'd0));
		emit(s_word(12'd24, 5'd9, 5'd0));
		// load-use
		emit(i_word(12'd32, 5'd0, 3'b010, 5'd10, op_load));
		emit(r_word(7'h00, 5'd1, 5'd10, f3_add, 5'd11));
		emit(s_word(12'd28, 5'd11, 5'd0));
		// taken beq skips both shadow stores
		emit(b_word(13'd12, 5'd12, 5'd12, f3_beq));
		emit(s_word(12'd36, 5'd1, 5'd0));
		emit(s_word(12'd40, 5'd2, 5'd0));
		emit(b_word(13'd8, 5'd0, 5'd12, f3_beq));
		emit(s_word(12'd44, 5'd12, 5'd0));
		emit(b_word(13'd12, 5'd0, 5'd12, f3_bne));
		emit(s_word(12'd48, 5'd4, 5'd0));
		emit(s_word(12'd52, 5'd5, 5'd0));
		emit(b_word(13'd8, 5'd12, 5'd12, f3_bne));
		emit(s_word(12'd56, 5'd6, 5'd0));
		emit(i_word(12'd0, 5'd0, 3'b010, 5'd13, op_load));
		emit(s_word(12'd60, 5'd13, 5'd0));
	endtask

	// ------------------------------------------------------------
	// unpipelined ISA model that fills exp_q with the store stream
	// ------------------------------------------------------------
	function automatic int run_model();
		logic [31:0] regs [32];
		logic [31:0] m [16];
		logic [31:0] pc;
		logic [31:0] pc_next;
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] opb;
		logic [31:0] res;
		logic [31:0] ea;
		logic        wr;
		dmem_req_t   st;
		int          steps;
		m = data_mem;
		for (int i = 0; i < 32; i++) begin
			regs[i] = '0;
		end
		pc = '0;
		steps = 0;
		while (pc[31:2] < prog_len && steps < 1000) begin
			w = prog[pc[7:2]];
			a = regs[w[19:15]];
			b = regs[w[24:20]];
			pc_next = pc + 4;
			wr = 1'b0;
			res = '0;
			opb = (w[6:0] == 7'b0110011) ? b : {{20{w[31]}}, w[31:20]};
			case (w[6:0])
				7'b0110011, 7'b0010011: begin
					wr = 1'b1;
					case (w[14:12])
						3'b010: res = ($signed(a) < $signed(opb)) ? 32'd1 : 32'd0;
						3'b110: res = a | opb;
						3'b111: res = a & opb;
						default: res = (w[6:0] == 7'b0110011 && w[30]) ? a - opb : a + opb;
					endcase
				end
				7'b0000011: begin
					wr = 1'b1;
					ea = a + opb;
					res = m[ea[5:2]];
				end
				7'b0100011: begin
					ea = a + {{20{w[31]}}, w[31:25], w[11:7]};
					m[ea[5:2]] = b;
					st = '0;
					st.wen = 1'b1;
					st.addr = ea[31:2];
					st.wdata = b;
					exp_q.push_back(st);
				end
				7'b1100011: begin
					if ((w[14:12] == 3'b000 && a == b) || (w[14:12] == 3'b001 && a != b)) begin
						pc_next = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
					end
				end
				default: wr = 1'b0;
			endcase
			if (wr && w[11:7] != 5'd0) begin
				regs[w[11:7]] = res;
			end
			pc = pc_next;
			steps++;
		end
		return steps;
	endfunction

	task automatic abort_run();
		$display("Done: errors found");
		$fatal(1);
	endtask

	task automatic check_store(input dmem_req_t got, input dmem_req_t exp);
		if (got.ren !== exp.ren) begin
			$display("error: dmem.ren expected %h actual %h", exp.ren, got.ren);
			abort_run();
		end else if (got.addr !== exp.addr) begin
			$display("error: dmem.addr expected %h actual %h", exp.addr, got.addr);
			abort_run();
		end else if (got.wdata !== exp.wdata) begin
			$display("error: dmem.wdata expected %h actual %h", exp.wdata, got.wdata);
			abort_run();
		end
	endtask

	// sampled half a cycle before the edge that accepts the request
	always @(negedge clk) begin
		if (rst_n && dmem.wen && !dmem_stall) begin
			if (exp_q.size() == 0) begin
				$display("store to word %h seen after the last expected store", dmem.addr);
				abort_run();
			end else begin
				check_store(dmem, exp_q.pop_front());
				data_mem[dmem.addr[3:0]] = dmem.wdata;
				if (exp_q.size() == 0) begin
					all_seen = 1'b1;
				end
			end
		end
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		dmem_stall = 1'b0;
		all_seen = 1'b0;
		cycles = 0;
		prog_len = 0;
		for (int i = 0; i < 64; i++) begin
			prog[i] = nop_word;
		end
		for (int i = 0; i < 16; i++) begin
			data_mem[i] = $random(seed);
		end
		build_program();
		n_instr = run_model();
		limit = 10 * n_instr + 100;
		repeat (5) @(posedge clk);
		#10 rst_n = 1'b1;
		while (!all_seen && cycles < limit) begin
			@(posedge clk);
			#10;
			rnd = $random(seed);
			dmem_stall = (rnd[1:0] == 2'b00);
			cycles++;
		end
		if (all_seen) begin
			$display("Done: no errors");
			$finish;
		end else begin
			$display("timeout after %0d cycles, %0d stores never arrived", cycles, exp_q.size());
			abort_run();
		end
	end

endmodule

`default_nettype wire

/* src.f */
verilog/rv_isa_pkg.sv
verilog/rv_pipe_pkg.sv
verilog/rv_fetch.sv
verilog/rv_regfile.sv
verilog/rv_decode.sv
verilog/rv_hazard.sv
verilog/rv_execute.sv
verilog/rv_mem_wb.sv
verilog/rv_core.sv
bench/rv_core_tb.sv
